/* list.f */
hw/riscv_dcache_pkg.sv
hw/riscv_dcache_line_ram.sv
hw/riscv_dcache_datapath.sv
hw/riscv_dcache_fsm.sv
hw/riscv_dcache_main_mem.sv
hw/riscv_data_cache.sv
verification/riscv_dcache_tb.sv

/* verification/riscv_dcache_tb.sv */
`timescale 1ns/10ps

module riscv_dcache_tb;

  import riscv_dcache_pkg::*;

  localparam int WAIT_LIMIT = 50;   // cycles per stall wait

  logic                  clk;
  logic                  rst_n;
  cpu_req_t              cpu_req;
  logic [CPU_WIDTH-1:0]  cpu_rdata;
  logic                  cpu_stall;

  logic [7:0]            ref_mem [MEM_BYTES];   // byte image of main memory
  logic [ADDR_W-OFF_W-1:0] resident [CACHE_LINES];   // line address held per index
  logic                  resident_ok [CACHE_LINES];
  int                    errors;
  int                    timeouts;
  integer                seed;

  riscv_data_cache i_dut (
    .i_riscv_dcache_clk (clk),
    .i_rst_n            (rst_n),
    .i_cpu_req          (cpu_req),
    .o_cpu_rdata        (cpu_rdata),
    .o_cpu_stall        (cpu_stall)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference model and compares
  ////////////////////////////////////////////////////////////////////////////

  function automatic int width_bytes(input store_src_e src);
    case (src)
      st_byte: return 1;
      st_half: return 2;
      st_word: return 4;
      default: return 8;
    endcase
  endfunction

  // aligned 8 bytes in little endian order
  function automatic logic [CPU_WIDTH-1:0] expected_load(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0]    base;
    logic [CPU_WIDTH-1:0] val;
    base = {addr[ADDR_W-1:3], 3'b000};
    for (int i = 0; i < 8; i++) begin
      val[i*8 +: 8] = ref_mem[base + i];
    end
    return val;
  endfunction

  // direct mapped, one line per index
  function automatic logic line_resident(input logic [ADDR_W-1:0] addr);
    logic [INDEX_W-1:0] idx;
    idx = addr[OFF_W +: INDEX_W];
    return resident_ok[idx] && (resident[idx] == addr[ADDR_W-1:OFF_W]);
  endfunction

  task automatic check_rdata(input string name, input logic [CPU_WIDTH-1:0] got,
                             input logic [CPU_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_stall(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // cpu port
  ////////////////////////////////////////////////////////////////////////////

  // called 2 ns after a rising edge and returns 2 ns after the completing edge
  task automatic access(input logic wr, input store_src_e src, input logic [ADDR_W-1:0] addr,
                        input logic [CPU_WIDTH-1:0] wdata,
                        output logic [CPU_WIDTH-1:0] rdata, output logic first_stall);
    int n;
    cpu_req.wren      = wr;
    cpu_req.rden      = !wr;
    cpu_req.store_src = src;
    cpu_req.addr      = addr;
    cpu_req.wdata     = wdata;
    n = 0;
    @(negedge clk);
    first_stall = cpu_stall;   // request cycle
    while (cpu_stall && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (cpu_stall) begin
      $display("timeout: stall still high after %0d cycles at address %h", WAIT_LIMIT, addr);
      timeouts++;
    end
    rdata = cpu_rdata;
    @(posedge clk);   // request completes here
    #2;
    cpu_req.wren = 1'b0;
    cpu_req.rden = 1'b0;
    resident[addr[OFF_W +: INDEX_W]]    = addr[ADDR_W-1:OFF_W];   // write allocate
    resident_ok[addr[OFF_W +: INDEX_W]] = 1'b1;
  endtask

  task automatic store_data(input store_src_e src, input logic [ADDR_W-1:0] addr,
                            input logic [CPU_WIDTH-1:0] data);
    logic [CPU_WIDTH-1:0] unused_rdata;
    logic                 first_stall;
    access(1'b1, src, addr, data, unused_rdata, first_stall);
    for (int i = 0; i < width_bytes(src); i++) begin
      ref_mem[addr + i] = data[i*8 +: 8];   // data sits in the low bytes
    end
  endtask

  task automatic load_check(input logic [ADDR_W-1:0] addr, output logic first_stall);
    logic [CPU_WIDTH-1:0] got;
    access(1'b0, st_double, addr, '0, got, first_stall);
    check_rdata($sformatf("o_cpu_rdata[%h]", addr), got, expected_load(addr));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_loads();
    logic [ADDR_W-1:0] addrs [4];
    logic              stall;
    addrs = '{10'h000, 10'h118, 10'h2a0, 10'h3f8};   // one per index
    @(negedge clk);
    check_stall("o_cpu_stall no request", cpu_stall, 1'b0);
    @(posedge clk);
    #2;
    foreach (addrs[i]) begin
      load_check(addrs[i], stall);
      check_stall($sformatf("o_cpu_stall first cycle [%h]", addrs[i]), stall, 1'b1);
    end
  endtask

  task automatic store_then_load();
    logic stall;
    store_data(st_double, 10'h240, 64'h0123_4567_89ab_cdef);
    load_check(10'h240, stall);
    check_stall("o_cpu_stall hit load", stall, 1'b0);
  endtask

  // junk in the upper wdata bytes must not land
  task automatic partial_store_merge();
    logic stall;
    store_data(st_byte,   10'h0c1, 64'hffff_ffff_ffff_ff5a);
    store_data(st_byte,   10'h0c6, 64'h1111_1111_1111_11a5);
    store_data(st_half,   10'h0c2, 64'h7777_7777_7777_1234);
    store_data(st_half,   10'h0c8, 64'hcccc_cccc_cccc_beef);
    store_data(st_word,   10'h0cc, 64'h5555_5555_dead_c0de);
    store_data(st_byte,   10'h0cb, 64'h0000_0000_0000_0042);
    load_check(10'h0c0, stall);
    check_stall("o_cpu_stall merged low load", stall, 1'b0);
    load_check(10'h0c8, stall);
    check_stall("o_cpu_stall merged high load", stall, 1'b0);
  endtask

  task automatic same_index_eviction();
    logic stall;
    store_data(st_double, 10'h1d0, 64'hfeed_face_cafe_f00d);
    store_data(st_double, 10'h210, 64'h0bad_beef_0bad_beef);   // same index so 0x1d0 goes
    load_check(10'h1d0, stall);
    check_stall("o_cpu_stall evicted load", stall, 1'b1);
    load_check(10'h210, stall);
    check_stall("o_cpu_stall reload", stall, 1'b1);
  endtask

  task automatic half_select_loads();
    logic stall;
    store_data(st_double, 10'h350, 64'h1010_2020_3030_4040);
    store_data(st_double, 10'h358, 64'h5050_6060_7070_8080);
    load_check(10'h358, stall);
    check_stall("o_cpu_stall upper half load", stall, 1'b0);
    load_check(10'h350, stall);
    check_stall("o_cpu_stall lower half load", stall, 1'b0);
    load_check(10'h35c, stall);   // low offset bits ignored
    check_stall("o_cpu_stall offset load", stall, 1'b0);
  endtask

  task automatic random_sequence();
    logic [31:0]          r;
    logic [ADDR_W-1:0]    addr;
    store_src_e           src;
    logic [CPU_WIDTH-1:0] data;
    logic                 stall;
    logic                 exp_stall;
    for (int n = 0; n < 40; n++) begin
      r    = $random(seed);
      src  = store_src_e'(r[11:10]);
      addr = r[ADDR_W-1:0] & ~ADDR_W'(width_bytes(src) - 1);   // natural alignment
      data = {$random(seed), $random(seed)};
      if (r[12]) begin
        store_data(src, addr, data);
      end else begin
        addr      = {addr[ADDR_W-1:3], 3'b000};
        exp_stall = !line_resident(addr);
        load_check(addr, stall);
        check_stall($sformatf("o_cpu_stall random load [%h]", addr), stall, exp_stall);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    cpu_req  = '0;
    errors   = 0;
    timeouts = 0;
    seed     = 32'ha0d04442;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    for (int i = 0; i < CACHE_LINES; i++) begin
      resident[i]    = '0;
      resident_ok[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    reset_loads();
    store_then_load();
    partial_store_merge();
    same_index_eviction();
    half_select_loads();
    random_sequence();

    $display("summary: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* hw/riscv_data_cache.sv */
`timescale 1ns/10ps

module riscv_data_cache (
  input  logic                                    i_riscv_dcache_clk,
  input  logic                                    i_rst_n,
  input  riscv_dcache_pkg::cpu_req_t              i_cpu_req,
  output logic [riscv_dcache_pkg::CPU_WIDTH-1:0]  o_cpu_rdata,
  output logic                                    o_cpu_stall
);

  import riscv_dcache_pkg::*;

  logic [INDEX_W-1:0]       index;
  tag_entry_t               tag_rd;
  tag_entry_t               tag_wr;
  line_t                    line_rd;
  line_t                    line_wr;
  line_t                    victim;
  logic                     hit;
  logic                     dirty;
  logic [ADDR_W-OFF_W-1:0]  mem_adr;
  fsm_ctrl_t                ctrl;
  wb_m2s_t                  wb_m2s;
  wb_s2m_t                  wb_s2m;

  ////////////////////////////////////////////////////////////////////////////
  // datapath and storage
  ////////////////////////////////////////////////////////////////////////////

  riscv_dcache_datapath u_datapath (
    .i_cpu_req    (i_cpu_req),
    .i_ctrl       (ctrl),
    .i_tag_rd     (tag_rd),
    .i_line_rd    (line_rd),
    .i_fill       (wb_s2m.dat),
    .o_index      (index),
    .o_tag_wr     (tag_wr),
    .o_line_wr    (line_wr),
    .o_hit        (hit),
    .o_dirty      (dirty),
    .o_mem_adr    (mem_adr),
    .o_victim     (victim),
    .o_cpu_rdata  (o_cpu_rdata)
  );

  riscv_dcache_line_ram #(
    .entry_t  (tag_entry_t),
    .DEPTH    (CACHE_LINES)
  ) u_tag_ram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst_n            (i_rst_n),
    .i_index            (index),
    .i_we               (ctrl.tag_we),
    .i_wdata            (tag_wr),
    .o_rdata            (tag_rd)
  );

  riscv_dcache_line_ram #(
    .entry_t  (line_t),
    .DEPTH    (CACHE_LINES)
  ) u_data_ram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst_n            (i_rst_n),
    .i_index            (index),
    .i_we               (ctrl.data_we),
    .i_wdata            (line_wr),
    .o_rdata            (line_rd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // controller and memory
  ////////////////////////////////////////////////////////////////////////////

  riscv_dcache_fsm u_fsm (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst_n            (i_rst_n),
    .i_cpu_req          (i_cpu_req),
    .i_hit              (hit),
    .i_dirty            (dirty),
    .i_mem_adr          (mem_adr),
    .i_victim           (victim),
    .i_wb               (wb_s2m),
    .o_wb               (wb_m2s),
    .o_ctrl             (ctrl),
    .o_cpu_stall        (o_cpu_stall)
  );

  riscv_dcache_main_mem u_main_mem (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst_n            (i_rst_n),
    .i_wb               (wb_m2s),
    .o_wb               (wb_s2m)
  );

endmodule

/* hw/riscv_dcache_main_mem.sv */
`timescale 1ns/10ps

module riscv_dcache_main_mem (
  input  logic                        i_riscv_dcache_clk,
  input  logic                        i_rst_n,
  input  riscv_dcache_pkg::wb_m2s_t   i_wb,
  output riscv_dcache_pkg::wb_s2m_t   o_wb
);

  import riscv_dcache_pkg::*;

  localparam int WAIT_W = $clog2(MEM_WAIT + 1);

  line_t              mem [MEM_LINES];
  logic [WAIT_W-1:0]  wait_cnt;
  logic               ack;

  ////////////////////////////////////////////////////////////////////////////
  // ack generation
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (!i_rst_n) begin
      wait_cnt <= '0;
      ack      <= 1'b0;
    end else if (i_wb.cyc && i_wb.stb && !ack) begin
      if (wait_cnt == WAIT_W'(MEM_WAIT)) begin
        wait_cnt <= '0;
        ack      <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end else begin
      ack <= 1'b0;   // single cycle ack
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // line array
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < MEM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else if (ack && i_wb.we) begin
      mem[i_wb.adr] <= i_wb.dat;   // write lands on the ack edge
    end
  end

  assign o_wb.ack = ack;
  assign o_wb.dat = mem[i_wb.adr];

endmodule

/* hw/riscv_dcache_fsm.sv */
`timescale 1ns/10ps

module riscv_dcache_fsm (
  input  logic                                                        i_riscv_dcache_clk,
  input  logic                                                        i_rst_n,
  input  riscv_dcache_pkg::cpu_req_t                                  i_cpu_req,
  input  logic                                                        i_hit,
  input  logic                                                        i_dirty,
  input  logic [riscv_dcache_pkg::ADDR_W-riscv_dcache_pkg::OFF_W-1:0] i_mem_adr,
  input  riscv_dcache_pkg::line_t                                     i_victim,
  input  riscv_dcache_pkg::wb_s2m_t                                   i_wb,
  output riscv_dcache_pkg::wb_m2s_t                                   o_wb,
  output riscv_dcache_pkg::fsm_ctrl_t                                 o_ctrl,
  output logic                                                        o_cpu_stall
);

  import riscv_dcache_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE      = 2'b00,
    S_WRITEBACK = 2'b01,
    S_REFILL    = 2'b10
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   req;

  assign req = i_cpu_req.wren || i_cpu_req.rden;

  ////////////////////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (!i_rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt   = state;
    o_ctrl      = '0;
    o_cpu_stall = 1'b0;

    // bus lines follow the datapath, they hold while the request holds
    o_wb.cyc = 1'b0;
    o_wb.stb = 1'b0;
    o_wb.we  = 1'b0;
    o_wb.adr = i_mem_adr;
    o_wb.dat = i_victim;

    case (state)
      S_IDLE: begin
        if (req && i_hit) begin
          if (i_cpu_req.wren) begin
            // store hit, merge into the line and mark dirty
            o_ctrl.data_we   = 1'b1;
            o_ctrl.tag_we    = 1'b1;
            o_ctrl.set_dirty = 1'b1;
          end
        end else if (req) begin
          o_cpu_stall = 1'b1;
          state_nxt   = i_dirty ? S_WRITEBACK : S_REFILL;
        end
      end

      S_WRITEBACK: begin
        o_cpu_stall       = 1'b1;
        o_ctrl.victim_sel = 1'b1;   // address from the stored tag
        o_wb.cyc          = 1'b1;
        o_wb.stb          = 1'b1;
        o_wb.we           = 1'b1;
        if (i_wb.ack) begin
          // victim now clean, idle sees a clean miss next
          o_ctrl.tag_we    = 1'b1;
          o_ctrl.set_dirty = 1'b0;
          state_nxt        = S_IDLE;
        end
      end

      S_REFILL: begin
        o_cpu_stall = 1'b1;
        o_wb.cyc    = 1'b1;
        o_wb.stb    = 1'b1;
        if (i_wb.ack) begin
          o_ctrl.fill_sel  = 1'b1;
          o_ctrl.data_we   = 1'b1;
          o_ctrl.tag_we    = 1'b1;
          o_ctrl.set_dirty = 1'b0;   // fresh line is clean
          state_nxt        = S_IDLE;
        end
      end

      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

endmodule

/* hw/riscv_dcache_datapath.sv */
`timescale 1ns/10ps

module riscv_dcache_datapath (
  input  riscv_dcache_pkg::cpu_req_t                              i_cpu_req,
  input  riscv_dcache_pkg::fsm_ctrl_t                             i_ctrl,
  input  riscv_dcache_pkg::tag_entry_t                            i_tag_rd,
  input  riscv_dcache_pkg::line_t                                 i_line_rd,
  input  riscv_dcache_pkg::line_t                                 i_fill,
  output logic [riscv_dcache_pkg::INDEX_W-1:0]                    o_index,
  output riscv_dcache_pkg::tag_entry_t                            o_tag_wr,
  output riscv_dcache_pkg::line_t                                 o_line_wr,
  output logic                                                    o_hit,
  output logic                                                    o_dirty,
  output logic [riscv_dcache_pkg::ADDR_W-riscv_dcache_pkg::OFF_W-1:0] o_mem_adr,
  output riscv_dcache_pkg::line_t                                 o_victim,
  output logic [riscv_dcache_pkg::CPU_WIDTH-1:0]                  o_cpu_rdata
);

  import riscv_dcache_pkg::*;

  logic [TAG_W-1:0]       req_tag;
  logic [INDEX_W-1:0]     req_index;
  logic [OFF_W-1:0]       req_off;
  logic [TAG_W+INDEX_W-1:0] req_line;   // tag and index together

  logic [LINE_BYTES-1:0]  width_mask;
  logic [LINE_BYTES-1:0]  byte_mask;
  line_t                  bit_mask;
  line_t                  wdata_sh;
  line_t                  merged;

  ////////////////////////////////////////////////////////////////////////////
  // address split and hit
  ////////////////////////////////////////////////////////////////////////////

  assign {req_tag, req_index, req_off} = i_cpu_req.addr;
  assign req_line = {req_tag, req_index};
  assign o_index  = req_index;

  assign o_hit   = i_tag_rd.valid && (i_tag_rd.tag == req_line);
  assign o_dirty = i_tag_rd.valid && i_tag_rd.dirty;   // only a valid line needs writeback

  ////////////////////////////////////////////////////////////////////////////
  // store merge
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (i_cpu_req.store_src)
      st_byte:   width_mask = LINE_BYTES'(16'h0001);
      st_half:   width_mask = LINE_BYTES'(16'h0003);
      st_word:   width_mask = LINE_BYTES'(16'h000f);
      default:   width_mask = LINE_BYTES'(16'h00ff);   // double
    endcase
    byte_mask = width_mask << req_off;
    for (int i = 0; i < LINE_BYTES; i++) begin
      bit_mask[i*8 +: 8] = {8{byte_mask[i]}};
    end
  end

  // aligned stores only, so the shifted data never wraps
  assign wdata_sh = {{(DATA_WIDTH-CPU_WIDTH){1'b0}}, i_cpu_req.wdata} << {req_off, 3'b000};
  assign merged   = (i_line_rd & ~bit_mask) | (wdata_sh & bit_mask);

  assign o_line_wr = i_ctrl.fill_sel ? i_fill : merged;

  ////////////////////////////////////////////////////////////////////////////
  // tag entry, memory side, load data
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    o_tag_wr.valid = 1'b1;
    o_tag_wr.dirty = i_ctrl.set_dirty;
    // writeback keeps the old tag and just cleans it
    o_tag_wr.tag   = i_ctrl.victim_sel ? i_tag_rd.tag : req_line;
  end

  assign o_mem_adr = i_ctrl.victim_sel ? i_tag_rd.tag : req_line;
  assign o_victim  = i_line_rd;

  // addr[3] picks the half
  assign o_cpu_rdata = i_cpu_req.addr[3] ? i_line_rd[DATA_WIDTH-1:CPU_WIDTH]
                                         : i_line_rd[CPU_WIDTH-1:0];

endmodule

/* hw/riscv_dcache_line_ram.sv */
`timescale 1ns/10ps

module riscv_dcache_line_ram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 4
) (
  input  logic                      i_riscv_dcache_clk,
  input  logic                      i_rst_n,
  input  logic [$clog2(DEPTH)-1:0]  i_index,
  input  logic                      i_we,
  input  entry_t                    i_wdata,
  output entry_t                    o_rdata
);

  entry_t mem [DEPTH];

  // async read, the hit path needs it in the request cycle
  assign o_rdata = mem[i_index];

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;   // tag entries come up invalid
      end
    end else if (i_we) begin
      mem[i_index] <= i_wdata;
    end
  end

endmodule

/* hw/riscv_dcache_pkg.sv */
package riscv_dcache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH  = 128;                      // bits per line
  localparam int CPU_WIDTH   = 64;
  localparam int MEM_BYTES   = 1024;
  localparam int LINE_BYTES  = DATA_WIDTH / 8;           // 16
  localparam int CACHE_LINES = 4;

  localparam int ADDR_W      = $clog2(MEM_BYTES);        // 10 bits
  localparam int OFF_W       = $clog2(LINE_BYTES);       // 4 bits
  localparam int INDEX_W     = $clog2(CACHE_LINES);      // 2 bits
  localparam int TAG_W       = ADDR_W - OFF_W - INDEX_W; // 4 bits

  localparam int MEM_LINES   = MEM_BYTES / LINE_BYTES;   // 64
  localparam int MEM_WAIT    = 2;                        // ack hold-off cycles

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // store width, same encoding as the core's store_src
  typedef enum logic [1:0] {
    st_byte   = 2'b00,
    st_half   = 2'b01,
    st_word   = 2'b10,
    st_double = 2'b11
  } store_src_e;

  typedef logic [DATA_WIDTH-1:0] line_t;

  // tag field keeps the full line address, so a victim needs no index splice
  typedef struct packed {
    logic                       valid;
    logic                       dirty;
    logic [TAG_W+INDEX_W-1:0]   tag;
  } tag_entry_t;

  typedef struct packed {
    logic                   wren;
    logic                   rden;
    store_src_e             store_src;
    logic [ADDR_W-1:0]      addr;
    logic [CPU_WIDTH-1:0]   wdata;
  } cpu_req_t;

  // wishbone classic, one line per beat
  typedef struct packed {
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic [ADDR_W-OFF_W-1:0]    adr;   // line address
    line_t                      dat;
  } wb_m2s_t;

  typedef struct packed {
    logic   ack;
    line_t  dat;
  } wb_s2m_t;

  typedef struct packed {
    logic tag_we;
    logic set_dirty;
    logic data_we;
    logic fill_sel;     // line from memory
    logic victim_sel;   // memory address from stored tag
  } fsm_ctrl_t;

endpackage
